// File: common/retire_pkg.sv
package retire_pkg;

    // register file sizes.
    localparam int arch_regs = 32;
    localparam int arch_w = 5;
    localparam int phys_regs = 64;
    localparam int pr_w = 6;

    // retirement is three wide.
    localparam int retire_width = 3;

    // reorder buffer geometry.
    localparam int rob_depth = 16;
    localparam int rob_idx_w = 4;

    // free list geometry.
    localparam int fl_depth = 64;
    localparam int fl_idx_w = 6;
    localparam int fl_reset_free = 32; // p32 to p63 free out of reset.

    // what the renamer hands to the rob.
    typedef struct packed {
        logic [arch_w-1:0] arch_reg;
        logic [pr_w-1:0]   t_new;              // newly allocated physical reg.
        logic [pr_w-1:0]   t_old;              // previous mapping, freed at retire.
        logic              precise_state_need; // e.g. branch mispredict.
    } dispatch_t;

    typedef struct packed {
        dispatch_t inst;
        logic      completed;
    } rob_entry_t;

    // one retire slot, shared by the map table, the free list and the top.
    typedef struct packed {
        logic              en;
        logic [arch_w-1:0] arch_reg;
        logic [pr_w-1:0]   t_new;
        logic [pr_w-1:0]   t_old;
    } retire_pkt_t;

    typedef struct packed {
        logic                              valid;
        logic [arch_regs-1:0][pr_w-1:0]    map; // restored rename map.
    } recover_t;

endpackage

// File: design/rob/rob.sv
`timescale 1ns/1ps

module rob import retire_pkg::*; (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                dispatch_valid,
    input  dispatch_t                           dispatch_data,
    input  logic                                complete_valid,
    input  logic [rob_idx_w-1:0]                complete_idx,
    input  logic [1:0]                          retire_count,
    input  logic                                flush,
    output logic                                dispatch_ready,
    output logic [rob_idx_w-1:0]                dispatch_idx,
    output rob_entry_t [retire_width-1:0]       head_entries,
    output logic [retire_width-1:0]             head_valid
);

    rob_entry_t entries [rob_depth];

    logic [rob_idx_w-1:0] head;
    logic [rob_idx_w-1:0] tail;
    logic [rob_idx_w:0]   count;       // occupancy, 0 to rob_depth.
    logic                 dispatch_fire;
    logic [rob_idx_w-1:0] cmp_off;     // distance of completion target from head.

    assign dispatch_ready = (count != rob_depth) && !flush;
    assign dispatch_fire = dispatch_valid && dispatch_ready;
    assign dispatch_idx = tail;
    assign cmp_off = complete_idx - head;

    // head window, slot 2 holds the oldest entry.
    always_comb begin
        for (int s = 0; s < retire_width; s++) begin
            head_entries[s] = entries[head + rob_idx_w'(retire_width - 1 - s)];
            // nothing retires while a flush is in progress.
            head_valid[s] = (int'(count) > (retire_width - 1 - s)) && !flush;
        end
    end

    // pointers and occupancy.
    always_ff @(posedge clock) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else if (flush) begin
            head <= tail; // drop everything in flight.
            count <= '0;
        end else begin
            head <= head + rob_idx_w'(retire_count);
            if (dispatch_fire) begin
                tail <= tail + 1'b1;
            end
            count <= count + (rob_idx_w+1)'(dispatch_fire) - (rob_idx_w+1)'(retire_count);
        end
    end

    // entry storage.
    always_ff @(posedge clock) begin
        if (dispatch_fire) begin
            entries[tail].inst <= dispatch_data;
            entries[tail].completed <= 1'b0;
        end
        if (complete_valid) begin
            entries[complete_idx].completed <= 1'b1;
        end
    end

    // completion must name an occupied entry.
    a_complete_occupied: assert property (@(posedge clock) disable iff (reset)
        complete_valid |-> ((rob_idx_w+1)'(cmp_off) < count));

    // retire stage can only see what is there.
    a_retire_le_count: assert property (@(posedge clock) disable iff (reset)
        (rob_idx_w+1)'(retire_count) <= count);

endmodule

// File: design/retire_stage.sv
`timescale 1ns/1ps

module retire_stage import retire_pkg::*; (
    input  rob_entry_t [retire_width-1:0]   head_entries,
    input  logic [retire_width-1:0]         head_valid,
    output retire_pkt_t [retire_width-1:0]  retire_pkts,
    output logic [1:0]                      retire_count,
    output logic                            recover_req,
    output logic [1:0]                      recover_slot
);

    logic [retire_width-1:0] retiring;

    // in-order priority chain, oldest slot first.
    always_comb begin
        logic go; // still allowed to retire at this slot.
        go = 1'b1;
        retiring = '0;
        recover_req = 1'b0;
        recover_slot = '0;
        for (int s = retire_width - 1; s >= 0; s--) begin
            if (go && head_valid[s] && head_entries[s].completed) begin
                retiring[s] = 1'b1;
                if (head_entries[s].inst.precise_state_need) begin
                    recover_req = 1'b1;
                    recover_slot = 2'(s);
                    go = 1'b0; // younger slots wait for the flush.
                end
            end else begin
                go = 1'b0;
            end
        end
    end

    // r0 writers retire but never touch the map or free list.
    always_comb begin
        for (int s = 0; s < retire_width; s++) begin
            retire_pkts[s].en = retiring[s] && (head_entries[s].inst.arch_reg != '0);
            retire_pkts[s].arch_reg = head_entries[s].inst.arch_reg;
            retire_pkts[s].t_new = head_entries[s].inst.t_new;
            retire_pkts[s].t_old = head_entries[s].inst.t_old;
        end
    end

    // count includes r0 writers.
    always_comb begin
        retire_count = '0;
        for (int s = 0; s < retire_width; s++) begin
            retire_count = retire_count + 2'(retiring[s]);
        end
    end

endmodule

// File: design/arch_map_table.sv
`timescale 1ns/1ps

module arch_map_table import retire_pkg::*; (
    input  logic                            clock,
    input  logic                            reset,
    input  retire_pkt_t [retire_width-1:0]  retire_pkts,
    output logic [arch_regs-1:0][pr_w-1:0]  map_next
);

    logic [arch_regs-1:0][pr_w-1:0] map; // committed map.

    // oldest slot first so the youngest write wins.
    always_comb begin
        map_next = map;
        for (int s = retire_width - 1; s >= 0; s--) begin
            if (retire_pkts[s].en) begin
                map_next[retire_pkts[s].arch_reg] = retire_pkts[s].t_new;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int r = 0; r < arch_regs; r++) begin
                map[r] <= pr_w'(r); // identity, ri to pi.
            end
        end else begin
            map <= map_next;
        end
    end

    // r0 stays bound to p0 for good.
    a_r0_fixed: assert property (@(posedge clock) disable iff (reset)
        map_next[0] == map[0]);

endmodule

// File: design/free_list/free_list.sv
`timescale 1ns/1ps

module free_list import retire_pkg::*; (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            alloc_valid,
    input  retire_pkt_t [retire_width-1:0]  retire_pkts,
    input  logic                            flush,
    output logic                            alloc_ready,
    output logic [pr_w-1:0]                 alloc_preg,
    output logic [fl_idx_w:0]               free_count
);

    logic [pr_w-1:0] queue [fl_depth];

    logic [fl_idx_w-1:0] head;                          // next reg to hand out.
    logic [fl_idx_w-1:0] tail;                          // next push slot.
    logic [fl_idx_w-1:0] push_addr [retire_width];
    logic [1:0]          push_n;
    logic                alloc_fire;

    assign alloc_ready = (free_count != '0) && !flush;
    assign alloc_fire = alloc_valid && alloc_ready;
    assign alloc_preg = queue[head];

    // pack the enabled t_old values behind the tail, oldest first.
    always_comb begin
        push_n = '0;
        for (int s = retire_width - 1; s >= 0; s--) begin
            push_addr[s] = tail + fl_idx_w'(push_n);
            if (retire_pkts[s].en) begin
                push_n = push_n + 2'd1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head <= '0;
            tail <= fl_idx_w'(phys_regs - fl_reset_free);
            free_count <= (fl_idx_w+1)'(fl_reset_free);
        end else if (flush) begin
            // everything younger than the recovery comes back.
            head <= tail - fl_idx_w'(fl_reset_free);
            free_count <= (fl_idx_w+1)'(fl_reset_free);
        end else begin
            if (alloc_fire) begin
                head <= head + 1'b1;
            end
            tail <= tail + fl_idx_w'(push_n);
            free_count <= free_count - (fl_idx_w+1)'(alloc_fire)
                        + (fl_idx_w+1)'(push_n);
        end
    end

    // the initial contents are p32 to p63.
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < phys_regs - fl_reset_free; i++) begin
                queue[i] <= pr_w'(fl_reset_free + i);
            end
        end else begin
            for (int s = 0; s < retire_width; s++) begin
                if (retire_pkts[s].en) begin
                    queue[push_addr[s]] <= retire_pkts[s].t_old;
                end
            end
        end
    end

    // a leak or a double free would push this past capacity.
    a_count_bound: assert property (@(posedge clock) disable iff (reset)
        free_count <= fl_depth);

endmodule

// File: design/recover_unit.sv
`timescale 1ns/1ps

module recover_unit import retire_pkg::*; (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            recover_req,
    input  logic [arch_regs-1:0][pr_w-1:0]  map_next,
    output recover_t                        recover,
    output logic                            flush
);

    // one-cycle pulse after the recovering retire.
    always_ff @(posedge clock) begin
        if (reset) begin
            recover.valid <= 1'b0;
        end else begin
            recover.valid <= recover_req;
        end
        if (recover_req) begin
            recover.map <= map_next; // already holds the recovering slot's write.
        end
    end

    assign flush = recover.valid;

    // the rob head window is blanked during flush.
    a_no_req_in_flush: assert property (@(posedge clock) disable iff (reset)
        flush |-> !recover_req);

endmodule

// File: design/retire_unit_top.sv
`timescale 1ns/1ps

module retire_unit_top import retire_pkg::*; (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            dispatch_valid,
    input  dispatch_t                       dispatch_data,
    input  logic                            complete_valid,
    input  logic [rob_idx_w-1:0]            complete_idx,
    input  logic                            alloc_valid,
    output logic                            dispatch_ready,
    output logic [rob_idx_w-1:0]            dispatch_idx,
    output logic                            alloc_ready,
    output logic [pr_w-1:0]                 alloc_preg,
    output retire_pkt_t [retire_width-1:0]  retire_pkts,
    output logic [fl_idx_w:0]               free_count,
    output recover_t                        recover
);

    rob_entry_t [retire_width-1:0]  head_entries;
    logic [retire_width-1:0]        head_valid;
    logic [1:0]                     retire_count;
    logic                           recover_req;
    logic [arch_regs-1:0][pr_w-1:0] map_next;
    logic                           flush;

    rob rob_inst (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_data  (dispatch_data),
        .complete_valid (complete_valid),
        .complete_idx   (complete_idx),
        .retire_count   (retire_count),
        .flush          (flush),
        .dispatch_ready (dispatch_ready),
        .dispatch_idx   (dispatch_idx),
        .head_entries   (head_entries),
        .head_valid     (head_valid)
    );

    retire_stage retire_stage_inst (
        .head_entries (head_entries),
        .head_valid   (head_valid),
        .retire_pkts  (retire_pkts),
        .retire_count (retire_count),
        .recover_req  (recover_req),
        .recover_slot ()
    );

    arch_map_table arch_map_table_inst (
        .clock       (clock),
        .reset       (reset),
        .retire_pkts (retire_pkts),
        .map_next    (map_next)
    );

    free_list free_list_inst (
        .clock       (clock),
        .reset       (reset),
        .alloc_valid (alloc_valid),
        .retire_pkts (retire_pkts),
        .flush       (flush),
        .alloc_ready (alloc_ready),
        .alloc_preg  (alloc_preg),
        .free_count  (free_count)
    );

    recover_unit recover_unit_inst (
        .clock       (clock),
        .reset       (reset),
        .recover_req (recover_req),
        .map_next    (map_next),
        .recover     (recover),
        .flush       (flush)
    );

endmodule

// File: bench/retire_model.svh
`ifndef RETIRE_MODEL_SVH
`define RETIRE_MODEL_SVH

// one in-flight instruction as the bench sees it.
typedef struct {
    dispatch_t            inst;
    logic                 completed;
    logic [rob_idx_w-1:0] idx;       // rob slot it was given.
} model_entry_t;

model_entry_t         model_q[$];               // oldest at the front.
logic [pr_w-1:0]      committed_map [arch_regs];
logic [pr_w-1:0]      spec_map [arch_regs];     // renamer view, ahead of retirement.
logic [pr_w-1:0]      free_q[$];                // next register to hand out at the front.
logic [rob_idx_w-1:0] model_tail;               // rob slot of the next dispatch.

function automatic void model_reset();
    model_q.delete();
    free_q.delete();
    for (int r = 0; r < arch_regs; r++) begin
        committed_map[r] = pr_w'(r);
        spec_map[r] = pr_w'(r);
    end
    for (int p = phys_regs - fl_reset_free; p < phys_regs; p++) begin
        free_q.push_back(pr_w'(p)); // p32 to p63.
    end
    model_tail = '0;
endfunction

function automatic void model_push(input dispatch_t d, input logic [rob_idx_w-1:0] idx);
    model_entry_t e;
    e.inst = d;
    e.completed = 1'b0;
    e.idx = idx;
    model_q.push_back(e);
endfunction

function automatic void model_complete(input int pos);
    model_q[pos].completed = 1'b1;
endfunction

// everything younger is gone, renaming restarts from the committed state.
function automatic void model_flush();
    // their registers go back ahead of the free ones, in allocation order.
    for (int i = model_q.size() - 1; i >= 0; i--) begin
        if (model_q[i].inst.arch_reg != '0) begin
            free_q.push_front(model_q[i].inst.t_new);
        end
    end
    model_q.delete();
    foreach (spec_map[r]) begin
        spec_map[r] = committed_map[r];
    end
endfunction

// expected slots for this cycle, then retire them in program order.
function automatic int model_retire(output retire_pkt_t [retire_width-1:0] pkts,
                                    output logic recovering);
    int           n;
    model_entry_t e;
    n = 0;
    recovering = 1'b0;
    pkts = '0;
    while (n < retire_width && n < model_q.size() && !recovering) begin
        if (!model_q[n].completed) begin
            break;
        end
        e = model_q[n];
        pkts[retire_width-1-n].en = (e.inst.arch_reg != '0);
        pkts[retire_width-1-n].arch_reg = e.inst.arch_reg;
        pkts[retire_width-1-n].t_new = e.inst.t_new;
        pkts[retire_width-1-n].t_old = e.inst.t_old;
        recovering = e.inst.precise_state_need;
        n++;
    end
    for (int k = 0; k < n; k++) begin
        e = model_q.pop_front();
        if (e.inst.arch_reg != '0) begin
            committed_map[e.inst.arch_reg] = e.inst.t_new; // later retire overwrites.
            free_q.push_back(e.inst.t_old);                // t_old goes back.
        end
    end
    return n;
endfunction

`endif

// File: bench/retire_tb.sv
`timescale 1ns/1ps

module retire_tb import retire_pkg::*; ();

    localparam int mix_insts = 300;
    localparam int bp_insts = 24;
    localparam int watchdog_cycles = 40 * (mix_insts + bp_insts + 1);

    logic                           clock;
    logic                           reset;
    logic                           dispatch_valid;
    dispatch_t                      dispatch_data;
    logic                           complete_valid;
    logic [rob_idx_w-1:0]           complete_idx;
    logic                           alloc_valid;
    logic                           dispatch_ready;
    logic [rob_idx_w-1:0]           dispatch_idx;
    logic                           alloc_ready;
    logic [pr_w-1:0]                alloc_preg;
    retire_pkt_t [retire_width-1:0] retire_pkts;
    logic [fl_idx_w:0]              free_count;
    recover_t                       recover;

    int   planned;        // instructions still to dispatch in this test.
    int   checks;
    int   errors;
    int   retired;
    int   recoveries;
    int   tests;
    logic expect_recover;
    logic fence_next;     // next dispatch is an r0 recovery fence.

    `include "retire_model.svh"

    retire_unit_top retire_unit_top_inst (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clock);
        $display("watchdog expired after %0d cycles, the DUT stopped making progress",
                 watchdog_cycles);
        $display("RESULT: FAIL");
        $finish;
    end

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s, got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic drive_completion(input bit may_complete);
        int pick;
        if (may_complete && model_q.size() > 0 && $urandom_range(0, 2) != 0) begin
            pick = $urandom_range(0, model_q.size() - 1);
            complete_valid = 1'b1;
            complete_idx = model_q[pick].idx;
            model_complete(pick);
        end
    endtask

    task automatic drive_dispatch(input bit may_dispatch);
        logic [arch_w-1:0] areg;
        logic [pr_w-1:0]   exp_preg;
        if (may_dispatch && planned > 0 && dispatch_ready && $urandom_range(0, 3) != 0) begin
            areg = ($urandom_range(0, 7) == 0) ? '0 : arch_w'($urandom_range(1, arch_regs - 1));
            dispatch_data.precise_state_need = ($urandom_range(0, 11) == 0);
            if (fence_next) begin
                areg = '0;
                dispatch_data.precise_state_need = 1'b1;
                fence_next = 1'b0;
            end
            dispatch_data.arch_reg = areg;
            dispatch_data.t_new = '0;
            dispatch_data.t_old = '0;
            if (areg != '0) begin // r0 takes no register.
                exp_preg = free_q.pop_front();
                check(alloc_preg, exp_preg, "alloc preg");
                alloc_valid = 1'b1;
                dispatch_data.t_new = alloc_preg;
                dispatch_data.t_old = spec_map[areg];
                spec_map[areg] = alloc_preg;
            end
            dispatch_valid = 1'b1;
            check(dispatch_idx, model_tail, "dispatch idx");
            model_push(dispatch_data, dispatch_idx);
            model_tail++;
            planned--;
        end
    endtask

    // one clock: check what the DUT shows, then drive the next inputs.
    task automatic run_cycle(input bit may_dispatch, input bit may_complete);
        retire_pkt_t [retire_width-1:0] exp_pkts;
        logic                           recovering;
        logic                           flushing;
        @(posedge clock);
        #2;
        dispatch_valid = 1'b0;
        alloc_valid = 1'b0;
        complete_valid = 1'b0;
        flushing = expect_recover;
        check(recover.valid, expect_recover, "recover valid");
        check(free_count, free_q.size(), "free count");
        check(dispatch_ready, !flushing && model_q.size() < rob_depth, "dispatch ready");
        check(alloc_ready, !flushing && free_q.size() != 0, "alloc ready");
        if (flushing) begin
            for (int r = 0; r < arch_regs; r++) begin
                check(recover.map[r], committed_map[r], $sformatf("recover map r%0d", r));
            end
            model_flush();
            recoveries++;
        end
        retired += model_retire(exp_pkts, recovering);
        expect_recover = recovering;
        for (int s = 0; s < retire_width; s++) begin
            check(retire_pkts[s].en, exp_pkts[s].en, $sformatf("slot %0d en", s));
            if (exp_pkts[s].en) begin
                check(retire_pkts[s].arch_reg, exp_pkts[s].arch_reg, "retire arch_reg");
                check(retire_pkts[s].t_new, exp_pkts[s].t_new, "retire t_new");
                check(retire_pkts[s].t_old, exp_pkts[s].t_old, "retire t_old");
            end
        end
        if (!flushing) begin
            drive_completion(may_complete);
            drive_dispatch(may_dispatch);
        end
    endtask

    task automatic drain();
        while (planned > 0 || model_q.size() != 0 || expect_recover || fence_next) begin
            run_cycle(1'b1, 1'b1);
        end
        run_cycle(1'b0, 1'b0); // free count after the last flush.
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        $display("test %-14s %s, %0d errors", name,
                 (errors == errors_before) ? "passed" : "failed", errors - errors_before);
    endtask

    initial begin
        int errors_before;
        int recoveries_before;
        void'($urandom(32'h57e64400));
        reset = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_data = '0;
        complete_valid = 1'b0;
        complete_idx = '0;
        alloc_valid = 1'b0;
        checks = 0;
        errors = 0;
        retired = 0;
        recoveries = 0;
        tests = 0;
        expect_recover = 1'b0;
        fence_next = 1'b0;
        model_reset();
        repeat (16) @(posedge clock);
        #2;
        reset = 1'b0;

        errors_before = errors;
        planned = mix_insts;
        drain();
        report_test("random_mix", errors_before);

        // nothing completes, so the rob has to fill up and push back.
        errors_before = errors;
        planned = bp_insts;
        while (model_q.size() < rob_depth) begin
            run_cycle(1'b1, 1'b0);
        end
        repeat (4) begin
            run_cycle(1'b1, 1'b0);
        end
        check(model_q.size(), rob_depth, "entries held under back-pressure");
        check(planned, bp_insts - rob_depth, "dispatches left under back-pressure");
        drain();
        report_test("backpressure", errors_before);

        // r0 fence exposes the final committed map.
        errors_before = errors;
        recoveries_before = recoveries;
        planned = 1;
        fence_next = 1'b1;
        drain();
        check(recoveries - recoveries_before, 1, "fence recovery count");
        report_test("final_drain", errors_before);

        $display("tests %0d, checks %0d, errors %0d, retired %0d, recoveries %0d",
                 tests, checks, errors, retired, recoveries);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+bench
common/retire_pkg.sv
design/rob/rob.sv
design/retire_stage.sv
design/arch_map_table.sv
design/free_list/free_list.sv
design/recover_unit.sv
design/retire_unit_top.sv
bench/retire_tb.sv

// File: Bender.yml
package:
  name: retire_unit

sources:
  - files:
      - common/retire_pkg.sv
      - design/rob/rob.sv
      - design/retire_stage.sv
      - design/arch_map_table.sv
      - design/free_list/free_list.sv
      - design/recover_unit.sv
      - design/retire_unit_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/retire_tb.sv
